//--- build.f
+incdir+.
k5StackPkg.sv
usiBus.sv
gpioBlock.sv
sysTimerBlock.sv
ledBlinker.sv
k5StackTop.sv
tbK5StackTop.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the K5Stack testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tbK5StackTop -o simK5Stack

./obj_dir/simK5Stack > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- tbK5StackTop.sv
// K5Stack top testbench

`timescale 1ns/1ps
`default_nettype none

`include "k5Stack_defs.svh"

module tbK5StackTop;

  localparam int lpMaxCycles = 2000;

  logic                 iSCLK;
  logic                 qnARST;
  logic                 pllLocked;
  k5StackPkg::usiAdrs_t usiAdrs;
  k5StackPkg::usiData_t usiWd;
  logic                 usiWe;
  k5StackPkg::usiData_t usiRd;
  k5StackPkg::gpio_t    gpioIn;
  k5StackPkg::gpio_t    gpioOut;
  k5StackPkg::gpio_t    gpioOe;

  // Expected read words, popped one cycle before they are due
  int                   dueQ[$];
  k5StackPkg::usiData_t expQ[$];
  string                nameQ[$];
  logic                 expValid = 1'b0;
  k5StackPkg::usiData_t expWord = '0;
  string                expName = "";

  // GPIO register model
  k5StackPkg::gpio_t    mData = '0;
  k5StackPkg::gpio_t    mDir = '0;
  k5StackPkg::gpio_t    mAlt = '0;
  // {alt, dir, data} delayed to line up with the pins
  logic [3*`GPIO_WIDTH-1:0] regsD1 = '0;
  logic [3*`GPIO_WIDTH-1:0] regsD2 = '0;

  int                   cycleCnt = 0;
  int                   enCycle = 0;
  integer               seed;
  k5StackPkg::usiData_t cmpVal;
  logic                 ledPrev = 1'b0;
  int                   ledGap = 0;
  int                   ledEdges = 0;

  k5StackTop #(
    .pLedCntMax(15)
  ) k5StackTop_i (
    .iSCLK(iSCLK),     .qnARST(qnARST),   .pllLocked(pllLocked),
    .usiAdrs(usiAdrs), .usiWd(usiWd),     .usiWe(usiWe),   .usiRd(usiRd),
    .gpioIn(gpioIn),   .gpioOut(gpioOut), .gpioOe(gpioOe)
  );

  initial
  begin
    iSCLK = 1'b0;
    forever #5 iSCLK = ~iSCLK;
  end

  // --------------------------------------------------
  // Failure reporting
  // --------------------------------------------------
  task automatic abortRun();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic reportMismatch(input string name, input k5StackPkg::usiData_t expVal,
                                input k5StackPkg::usiData_t actVal);
    $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, expVal, actVal);
    abortRun();
  endtask

  task automatic reportError(input string msg);
    $display("ERROR: %s", msg);
    abortRun();
  endtask

  // --------------------------------------------------
  // Bus master
  // --------------------------------------------------
  function automatic k5StackPkg::usiAdrs_t makeAdrs(input k5StackPkg::blockSel_t blk,
                                                    input k5StackPkg::csrAdrs_t ofs);
    k5StackPkg::usiAdrs_t adrs;
    adrs = '0;
    adrs[`BLOCK_ADRS_LSB +: `BLOCK_ADRS_WIDTH] = blk;
    adrs[`CSR_ACTIVE_WIDTH-1:0] = ofs;
    return adrs;
  endfunction

  task automatic busIdle(input int cycles);
    repeat (cycles)
    begin
      @(posedge iSCLK);
      usiWe <= 1'b0;
    end
  endtask

  task automatic busWrite(input k5StackPkg::blockSel_t blk, input k5StackPkg::csrAdrs_t ofs,
                          input k5StackPkg::usiData_t data);
    @(posedge iSCLK);
    usiAdrs <= makeAdrs(blk, ofs);
    usiWd   <= data;
    usiWe   <= 1'b1;
    if (blk == `GPIO_ADRS_MAP)
    begin
      case (ofs)
        `GPIO_CSR_DATA: mData <= data[`GPIO_WIDTH-1:0];
        `GPIO_CSR_DIR:  mDir  <= data[`GPIO_WIDTH-1:0];
        `GPIO_CSR_ALT:  mAlt  <= data[`GPIO_WIDTH-1:0];
        default:        ;
      endcase
    end
  endtask

  // Drives on the current edge, answer checked 3 cycles after sampling
  task automatic issueRead(input k5StackPkg::blockSel_t blk, input k5StackPkg::csrAdrs_t ofs,
                           input k5StackPkg::usiData_t expVal, input string name);
    usiAdrs <= makeAdrs(blk, ofs);
    usiWe   <= 1'b0;
    dueQ.push_back(cycleCnt + 3);
    expQ.push_back(expVal);
    nameQ.push_back(name);
  endtask

  task automatic busRead(input k5StackPkg::blockSel_t blk, input k5StackPkg::csrAdrs_t ofs,
                         input k5StackPkg::usiData_t expVal, input string name);
    @(posedge iSCLK);
    issueRead(blk, ofs, expVal, name);
  endtask

  // Counter starts one cycle after enable reaches the CSR
  task automatic readTimerCount(input string name);
    @(posedge iSCLK);
    issueRead(`SYSTIMER_ADRS_MAP, `TMR_CSR_COUNT, 32'(cycleCnt - enCycle - 1), name);
  endtask

  // --------------------------------------------------
  // Monitors and assertions
  // --------------------------------------------------
  always @(posedge iSCLK)
  begin
    cycleCnt <= cycleCnt + 1;
    regsD1   <= {mAlt, mDir, mData};
    regsD2   <= regsD1;
    if (dueQ.size() > 0 && dueQ[0] == cycleCnt)
    begin
      expValid <= 1'b1;
      expWord  <= expQ.pop_front();
      expName  <= nameQ.pop_front();
      void'(dueQ.pop_front());
    end
    else
      expValid <= 1'b0;
  end

  // Heartbeat gap, first change after alt enable may come from the data bit
  always @(posedge iSCLK)
  begin
    ledPrev <= gpioOut[2];
    if (!regsD2[8])
    begin
      ledGap   <= 0;
      ledEdges <= 0;
    end
    else if (gpioOut[2] != ledPrev)
    begin
      ledGap   <= 1;
      ledEdges <= (ledEdges < 2) ? ledEdges + 1 : 2;
    end
    else
      ledGap <= ledGap + 1;
  end

  always @(posedge iSCLK)
  begin
    if (cycleCnt >= lpMaxCycles)
      reportError("timeout, the test sequence did not finish in time");
  end

  aResetRd: assert property (@(posedge iSCLK) (!qnARST || $rose(qnARST)) |-> (usiRd == '0))
    else reportMismatch("reset usiRd", '0, $sampled(usiRd));

  aResetPins: assert property (@(posedge iSCLK)
    (!qnARST || $rose(qnARST)) |-> (gpioOut == '0 && gpioOe == '0))
    else reportMismatch("reset pins", '0, 32'({$sampled(gpioOe), $sampled(gpioOut)}));

  aReadWord: assert property (@(posedge iSCLK) disable iff (!qnARST)
    expValid |-> (usiRd == expWord))
    else reportMismatch(expName, $sampled(expWord), $sampled(usiRd));

  aPinOe: assert property (@(posedge iSCLK) disable iff (!qnARST)
    gpioOe == regsD2[5:3])
    else reportMismatch("gpio direction pins", 32'($sampled(regsD2[5:3])),
                        32'($sampled(gpioOe)));

  aPinData: assert property (@(posedge iSCLK) disable iff (!qnARST)
    ((gpioOut ^ regsD2[2:0]) & ~regsD2[8:6]) == '0)
    else reportMismatch("gpio data pins", 32'($sampled(regsD2[2:0])),
                        32'($sampled(gpioOut)));

  aPllPin: assert property (@(posedge iSCLK) disable iff (!qnARST)
    regsD2[6] |-> (gpioOut[0] == pllLocked))
    else reportMismatch("pll lock pin", 32'($sampled(pllLocked)), 32'($sampled(gpioOut[0])));

  aLedPeriod: assert property (@(posedge iSCLK) disable iff (!qnARST)
    (regsD2[8] && ledEdges == 2 && gpioOut[2] != ledPrev) |-> (ledGap == 16))
    else reportMismatch("heartbeat period", 32'd16, 32'($sampled(ledGap)));

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial
  begin
    seed      = 55;
    qnARST    = 1'b0;
    pllLocked = 1'b0;
    usiAdrs   = '0;
    usiWd     = '0;
    usiWe     = 1'b0;
    gpioIn    = '0;
    repeat (10) @(posedge iSCLK);
    qnARST <= 1'b1;
    busIdle(2);

    // GPIO registers, reads back to back
    for (int i = 0; i < 8; i++)
    begin
      busWrite(`GPIO_ADRS_MAP, `GPIO_CSR_DATA, $random(seed));
      busWrite(`GPIO_ADRS_MAP, `GPIO_CSR_DIR, $random(seed));
      busIdle(1);
      busRead(`GPIO_ADRS_MAP, `GPIO_CSR_DATA, 32'(mData), "gpio readback");
      busRead(`GPIO_ADRS_MAP, `GPIO_CSR_DIR, 32'(mDir), "gpio readback");
    end

    // Synchronized input
    for (int i = 0; i < 6; i++)
    begin
      @(posedge iSCLK);
      gpioIn <= k5StackPkg::gpio_t'($random(seed));
      busIdle(3);
      busRead(`GPIO_ADRS_MAP, `GPIO_CSR_IN, 32'(gpioIn), "gpio input");
    end

    // Timer held, then running
    cmpVal = 32'hFFFF_0000;
    busWrite(`SYSTIMER_ADRS_MAP, `TMR_CSR_CMP, cmpVal);
    busIdle(2);
    busRead(`SYSTIMER_ADRS_MAP, `TMR_CSR_COUNT, '0, "timer disabled");
    busIdle(4);
    busRead(`SYSTIMER_ADRS_MAP, `TMR_CSR_COUNT, '0, "timer disabled");
    busRead(`SYSTIMER_ADRS_MAP, `TMR_CSR_FLAG, '0, "timer disabled");
    busWrite(`SYSTIMER_ADRS_MAP, `TMR_CSR_CTRL, 32'h1);
    enCycle = cycleCnt;
    busIdle(3);
    repeat (4)
    begin
      readTimerCount("timer count");
      readTimerCount("timer count");
      busIdle(2);
    end

    // Compare a few counts ahead
    cmpVal = 32'(cycleCnt - enCycle + 10);
    busWrite(`SYSTIMER_ADRS_MAP, `TMR_CSR_CMP, cmpVal);
    busIdle(14);
    busRead(`SYSTIMER_ADRS_MAP, `TMR_CSR_FLAG, 32'h1, "timer match");
    busWrite(`GPIO_ADRS_MAP, `GPIO_CSR_ALT, 32'h2);
    busIdle(4);
    assert (gpioOut[1] == 1'b1)
      else reportMismatch("timer match pin", 32'd1, 32'(gpioOut[1]));
    busWrite(`SYSTIMER_ADRS_MAP, `TMR_CSR_FLAG, 32'h1);
    busIdle(3);
    busRead(`SYSTIMER_ADRS_MAP, `TMR_CSR_FLAG, '0, "timer flag clear");
    busIdle(1);
    assert (gpioOut[1] == 1'b0)
      else reportMismatch("timer flag clear pin", '0, 32'(gpioOut[1]));

    // Unmapped block codes
    busWrite(3'd3, `GPIO_CSR_DATA, $random(seed));
    busWrite(3'd5, `TMR_CSR_CMP, $random(seed));
    busIdle(2);
    busRead(3'd1, `GPIO_CSR_DATA, '0, "unmapped read");
    busRead(3'd2, `GPIO_CSR_DIR, '0, "unmapped read");
    busRead(3'd3, `GPIO_CSR_DATA, '0, "unmapped read");
    busRead(3'd5, `TMR_CSR_CMP, '0, "unmapped read");
    busRead(`GPIO_ADRS_MAP, `GPIO_CSR_DATA, 32'(mData), "unmapped write");
    busRead(`SYSTIMER_ADRS_MAP, `TMR_CSR_CMP, cmpVal, "unmapped write");

    // Lock and heartbeat on pins 0 and 2
    busWrite(`GPIO_ADRS_MAP, `GPIO_CSR_ALT, 32'h5);
    busIdle(3);
    repeat (96)
    begin
      @(posedge iSCLK);
      pllLocked <= 1'($random(seed));
    end
    busIdle(6);

    if (dueQ.size() == 0)
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
    else
      reportError("some expected reads were never checked");
  end

endmodule

`default_nettype wire

//--- k5StackTop.sv
// K5Stack control backbone top

`timescale 1ns/1ps
`default_nettype none

`include "k5Stack_defs.svh"

module k5StackTop #(
  parameter int unsigned pLedCntMax = `LED_CNT_MAX
) (
  input  wire                   iSCLK,
  input  wire                   qnARST,
  input  logic                  pllLocked,
  // External USI master
  input  k5StackPkg::usiAdrs_t  usiAdrs,
  input  k5StackPkg::usiData_t  usiWd,
  input  logic                  usiWe,
  output k5StackPkg::usiData_t  usiRd,
  // GPIO pins
  input  k5StackPkg::gpio_t     gpioIn,
  output k5StackPkg::gpio_t     gpioOut,
  output k5StackPkg::gpio_t     gpioOe
);

  k5StackPkg::csrAdrs_t csrAdrs;
  k5StackPkg::usiData_t csrWd;
  logic                 gpioWe;
  logic                 timerWe;
  k5StackPkg::usiData_t gpioRd;
  k5StackPkg::usiData_t timerRd;
  logic                 matchFlag;
  logic                 led;
  k5StackPkg::gpio_t    altSrc;

  // --------------------------------------------------
  // Bus and slaves
  // --------------------------------------------------
  usiBus usiBus_i (
    .iSCLK(iSCLK),     .qnARST(qnARST),
    .usiAdrs(usiAdrs), .usiWd(usiWd),     .usiWe(usiWe),   .usiRd(usiRd),
    .csrAdrs(csrAdrs), .csrWd(csrWd),
    .gpioWe(gpioWe),   .timerWe(timerWe),
    .gpioRd(gpioRd),   .timerRd(timerRd)
  );

  gpioBlock gpioBlock_i (
    .iSCLK(iSCLK),     .qnARST(qnARST),
    .csrAdrs(csrAdrs), .csrWd(csrWd),     .csrWe(gpioWe),  .csrRd(gpioRd),
    .gpioIn(gpioIn),   .altSrc(altSrc),
    .gpioOut(gpioOut), .gpioOe(gpioOe)
  );

  sysTimerBlock sysTimerBlock_i (
    .iSCLK(iSCLK),     .qnARST(qnARST),
    .csrAdrs(csrAdrs), .csrWd(csrWd),     .csrWe(timerWe), .csrRd(timerRd),
    .matchFlag(matchFlag)
  );

  // Heartbeat
  ledBlinker #(
    .pCntMax(pLedCntMax)
  ) ledBlinker_i (
    .iSCLK(iSCLK), .qnARST(qnARST), .led(led)
  );

  // Alternate sources, pin 0 lock, pin 1 timer match, pin 2 heartbeat
  assign altSrc = {led, matchFlag, pllLocked};

endmodule

`default_nettype wire

//--- ledBlinker.sv
// Heartbeat LED divider

`timescale 1ns/1ps
`default_nettype none

`include "k5Stack_defs.svh"

module ledBlinker #(
  parameter int unsigned pCntMax = `LED_CNT_MAX
) (
  input  wire  iSCLK,
  input  wire  qnARST,
  output logic led
);

  localparam int lpCntWidth = (pCntMax > 0) ? $clog2(pCntMax + 1) : 1;

  logic [lpCntWidth-1:0] rCnt;
  logic                  cntWrap;

  assign cntWrap = (rCnt == lpCntWidth'(pCntMax));

  // Level flips once per pCntMax+1 cycles
  always_ff @(posedge iSCLK, negedge qnARST)
  begin
    if (!qnARST)
    begin
      rCnt <= '0;
      led  <= 1'b0;
    end
    else if (cntWrap)
    begin
      rCnt <= '0;
      led  <= ~led;
    end
    else
      rCnt <= rCnt + 1'b1;
  end

endmodule

`default_nettype wire

//--- sysTimerBlock.sv
// System timer block

`timescale 1ns/1ps
`default_nettype none

`include "k5Stack_defs.svh"

module sysTimerBlock (
  input  wire                   iSCLK,
  input  wire                   qnARST,
  // CSR port
  input  k5StackPkg::csrAdrs_t  csrAdrs,
  input  k5StackPkg::usiData_t  csrWd,
  input  logic                  csrWe,
  output k5StackPkg::usiData_t  csrRd,
  // Compare status
  output logic                  matchFlag
);

  logic                 rEn;
  k5StackPkg::usiData_t rCount;
  k5StackPkg::usiData_t rCmp;
  logic                 rFlag;
  logic                 ctrlWr;
  logic                 cntClr;
  logic                 flagClr;

  assign ctrlWr  = csrWe && (csrAdrs == `TMR_CSR_CTRL);
  // Bit 1 of control is a self-clearing counter reset
  assign cntClr  = ctrlWr && csrWd[1];
  assign flagClr = csrWe && (csrAdrs == `TMR_CSR_FLAG) && csrWd[0];

  // --------------------------------------------------
  // Control, compare and counter
  // --------------------------------------------------
  always_ff @(posedge iSCLK, negedge qnARST)
  begin
    if (!qnARST)
    begin
      rEn    <= 1'b0;
      rCmp   <= '0;
      rCount <= '0;
    end
    else
    begin
      if (ctrlWr)
        rEn <= csrWd[0];
      if (csrWe && (csrAdrs == `TMR_CSR_CMP))
        rCmp <= csrWd;
      if (cntClr)
        rCount <= '0;
      else if (rEn)
        rCount <= rCount + 1'b1;
    end
  end

  // Sticky match, a new match wins over a clear
  always_ff @(posedge iSCLK, negedge qnARST)
  begin
    if (!qnARST)
      rFlag <= 1'b0;
    else if (rEn && (rCount == rCmp))
      rFlag <= 1'b1;
    else if (flagClr)
      rFlag <= 1'b0;
  end

  // --------------------------------------------------
  // CSR read
  // --------------------------------------------------
  always_ff @(posedge iSCLK, negedge qnARST)
  begin
    if (!qnARST)
      csrRd <= '0;
    else
    begin
      case (csrAdrs)
        `TMR_CSR_CTRL:  csrRd <= k5StackPkg::usiData_t'(rEn);
        `TMR_CSR_COUNT: csrRd <= rCount;
        `TMR_CSR_CMP:   csrRd <= rCmp;
        `TMR_CSR_FLAG:  csrRd <= k5StackPkg::usiData_t'(rFlag);
        default:        csrRd <= '0;
      endcase
    end
  end

  assign matchFlag = rFlag;

  aHoldCount: assert property (@(posedge iSCLK) disable iff (!qnARST)
    (!rEn && !cntClr) |=> $stable(rCount))
    else $error("sysTimerBlock: count moved while disabled");

endmodule

`default_nettype wire

//--- gpioBlock.sv
// GPIO block

`timescale 1ns/1ps
`default_nettype none

`include "k5Stack_defs.svh"

module gpioBlock (
  input  wire                   iSCLK,
  input  wire                   qnARST,
  // CSR port
  input  k5StackPkg::csrAdrs_t  csrAdrs,
  input  k5StackPkg::usiData_t  csrWd,
  input  logic                  csrWe,
  output k5StackPkg::usiData_t  csrRd,
  // Pins
  input  k5StackPkg::gpio_t     gpioIn,
  input  k5StackPkg::gpio_t     altSrc,
  output k5StackPkg::gpio_t     gpioOut,
  output k5StackPkg::gpio_t     gpioOe
);

  k5StackPkg::gpio_t rData;
  k5StackPkg::gpio_t rDir;
  k5StackPkg::gpio_t rAlt;
  k5StackPkg::gpio_t rSync1;
  k5StackPkg::gpio_t rSync2;
  logic              rAnyWrite;

  // --------------------------------------------------
  // CSR write
  // --------------------------------------------------
  always_ff @(posedge iSCLK, negedge qnARST)
  begin
    if (!qnARST)
    begin
      rData     <= '0;
      rDir      <= '0;
      rAlt      <= '0;
      rAnyWrite <= 1'b0;
    end
    else if (csrWe)
    begin
      rAnyWrite <= 1'b1;
      case (csrAdrs)
        `GPIO_CSR_DATA: rData <= csrWd[`GPIO_WIDTH-1:0];
        `GPIO_CSR_DIR:  rDir  <= csrWd[`GPIO_WIDTH-1:0];
        `GPIO_CSR_ALT:  rAlt  <= csrWd[`GPIO_WIDTH-1:0];
        default:        ;
      endcase
    end
  end

  // Two-flop input synchronizer
  always_ff @(posedge iSCLK, negedge qnARST)
  begin
    if (!qnARST)
    begin
      rSync1 <= '0;
      rSync2 <= '0;
    end
    else
    begin
      rSync1 <= gpioIn;
      rSync2 <= rSync1;
    end
  end

  // --------------------------------------------------
  // CSR read, upper bits zero
  // --------------------------------------------------
  always_ff @(posedge iSCLK, negedge qnARST)
  begin
    if (!qnARST)
      csrRd <= '0;
    else
    begin
      case (csrAdrs)
        `GPIO_CSR_DATA: csrRd <= k5StackPkg::usiData_t'(rData);
        `GPIO_CSR_DIR:  csrRd <= k5StackPkg::usiData_t'(rDir);
        `GPIO_CSR_ALT:  csrRd <= k5StackPkg::usiData_t'(rAlt);
        `GPIO_CSR_IN:   csrRd <= k5StackPkg::usiData_t'(rSync2);
        default:        csrRd <= '0;
      endcase
    end
  end

  // Per-pin alternate source select
  assign gpioOut = (rAlt & altSrc) | (~rAlt & rData);
  assign gpioOe  = rDir;

  aOeQuiet: assert property (@(posedge iSCLK) disable iff (!qnARST)
    !rAnyWrite |-> (gpioOe == '0))
    else $error("gpioBlock: gpioOe active before any CSR write");

endmodule

`default_nettype wire

//--- usiBus.sv
// USI register bus

`timescale 1ns/1ps
`default_nettype none

`include "k5Stack_defs.svh"

module usiBus (
  input  wire                   iSCLK,
  input  wire                   qnARST,
  // Master side
  input  k5StackPkg::usiAdrs_t  usiAdrs,
  input  k5StackPkg::usiData_t  usiWd,
  input  logic                  usiWe,
  output k5StackPkg::usiData_t  usiRd,
  // Slave side
  output k5StackPkg::csrAdrs_t  csrAdrs,
  output k5StackPkg::usiData_t  csrWd,
  output logic                  gpioWe,
  output logic                  timerWe,
  input  k5StackPkg::usiData_t  gpioRd,
  input  k5StackPkg::usiData_t  timerRd
);

  k5StackPkg::blockSel_t reqBlk;
  k5StackPkg::blockSel_t rBlk1;
  // Block field lined up with slave read registers
  k5StackPkg::blockSel_t rBlk2;

  assign reqBlk = usiAdrs[`BLOCK_ADRS_LSB +: `BLOCK_ADRS_WIDTH];

  // --------------------------------------------------
  // Stage 1 request register and write decode
  // --------------------------------------------------
  always_ff @(posedge iSCLK, negedge qnARST)
  begin
    if (!qnARST)
    begin
      rBlk1   <= '0;
      csrAdrs <= '0;
      csrWd   <= '0;
      gpioWe  <= 1'b0;
      timerWe <= 1'b0;
    end
    else
    begin
      rBlk1   <= reqBlk;
      csrAdrs <= usiAdrs[`CSR_ACTIVE_WIDTH-1:0];
      csrWd   <= usiWd;
      gpioWe  <= usiWe && (reqBlk == `GPIO_ADRS_MAP);
      timerWe <= usiWe && (reqBlk == `SYSTIMER_ADRS_MAP);
    end
  end

  // --------------------------------------------------
  // Stages 2 and 3 read return
  // --------------------------------------------------
  always_ff @(posedge iSCLK, negedge qnARST)
  begin
    if (!qnARST)
    begin
      rBlk2 <= '0;
      usiRd <= '0;
    end
    else
    begin
      rBlk2 <= rBlk1;
      case (rBlk2)
        `GPIO_ADRS_MAP:     usiRd <= gpioRd;
        `SYSTIMER_ADRS_MAP: usiRd <= timerRd;
        default:            usiRd <= '0;
      endcase
    end
  end

  // One slave at most takes a write
  aOneStrobe: assert property (@(posedge iSCLK) disable iff (!qnARST)
    !(gpioWe && timerWe))
    else $error("usiBus: gpioWe and timerWe both high");

endmodule

`default_nettype wire

//--- k5StackPkg.sv
// K5Stack shared types

`default_nettype none

`include "k5Stack_defs.svh"

package k5StackPkg;

  // --------------------------------------------------
  // USI bus words
  // --------------------------------------------------
  typedef logic [`USI_BUS_WIDTH-1:0] usiData_t;
  typedef logic [`USI_BUS_WIDTH-1:0] usiAdrs_t;

  // Address fields
  typedef logic [`BLOCK_ADRS_WIDTH-1:0] blockSel_t;
  typedef logic [`CSR_ACTIVE_WIDTH-1:0] csrAdrs_t;

  // One bit per pin
  typedef logic [`GPIO_WIDTH-1:0] gpio_t;

endpackage

`default_nettype wire

//--- k5Stack_defs.svh
// K5Stack control backbone definitions

`ifndef K5STACK_DEFS_SVH
`define K5STACK_DEFS_SVH

// --------------------------------------------------
// USI bus geometry
// --------------------------------------------------
`define USI_BUS_WIDTH     32
`define BLOCK_ADRS_LSB    16
`define BLOCK_ADRS_WIDTH  3
`define CSR_ACTIVE_WIDTH  8
`define GPIO_WIDTH        3

// Block address map, codes 1 2 3 5 unmapped
`define GPIO_ADRS_MAP      3'h0
`define SYSTIMER_ADRS_MAP  3'h4

// --------------------------------------------------
// CSR offsets
// --------------------------------------------------
`define GPIO_CSR_DATA  8'h00
`define GPIO_CSR_DIR   8'h04
`define GPIO_CSR_ALT   8'h08
`define GPIO_CSR_IN    8'h0C

`define TMR_CSR_CTRL   8'h00
`define TMR_CSR_COUNT  8'h04
`define TMR_CSR_CMP    8'h08
`define TMR_CSR_FLAG   8'h0C

// Heartbeat divider, half period of 25M cycles
`define LED_CNT_MAX  24999999

`endif
